// ==== Makefile ====
# Verilator build and run for the integer math unit

VERILATOR ?= verilator
TOP       ?= math_unit_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
# Keep running past assertion errors so the testbench prints its verdict
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= *** PASSED ***

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the exact pass line shows up in the output
run: compile
	@$(SIM) $(RUN_ARGS) | awk -v msg='$(PASS_TEXT)' \
		'{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/math_unit_chk.sv ====
/*
  Concurrent assertions on the math unit top level
  Multiply latency, busy release, single divide pulse, reset state
*/
`timescale 1ns/1ps

module math_unit_chk (
  input logic               clk,
  input logic               rst_n,
  input logic               mul_start,
  input logic               result_valid,
  input math_unit_pkg::op_e result_op,
  input logic               div_busy
);
  int   fail_count = 0;
  logic div_out;

  assign div_out = result_valid && (result_op == math_unit_pkg::OP_DIV);

  // Every accepted multiply lands on the bus three cycles later
  mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
    mul_start |-> ##3 (result_valid && result_op == math_unit_pkg::OP_MUL))
  else begin
    $error("multiply result not on the bus three cycles after its start");
    fail_count++;
  end

  // Busy drops on the same edge that puts the divide result out
  busy_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(div_busy) |-> div_out)
  else begin
    $error("div_busy fell without a divide result on the bus");
    fail_count++;
  end

  single_div_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    div_out |=> !div_out)
  else begin
    $error("divide result held on the bus for two cycles");
    fail_count++;
  end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!result_valid && !div_busy))
  else begin
    $error("result_valid or div_busy high during reset");
    fail_count++;
  end

endmodule

// ==== bench/math_unit_scoreboard.sv ====
/*
  Scoreboard for the integer math unit
  Reference model for products, quotients and remainders,
  result checks at the DUT ports and per-phase counts
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module math_unit_scoreboard (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        mul_start,
  input logic                        div_start,
  input logic                        is_signed,
  input logic [`MATH_WIDTH-1:0]      left,
  input logic [`MATH_WIDTH-1:0]      right,
  input logic                        result_valid,
  input math_unit_pkg::op_e          result_op,
  input math_unit_pkg::result_word_u result,
  input logic                        div_busy
);
  localparam int W = `MATH_WIDTH;

  logic [2*W-1:0]           mul_exp[$];
  int                       mul_due[$];
  logic                     div_expected = 1'b0;
  math_unit_pkg::div_word_t div_exp;
  int                       cycle_no = 0;
  int                       phase_checks = 0;
  int                       phase_errors = 0;
  int                       total_checks = 0;
  int                       total_errors = 0;

  // Full-width two's-complement or unsigned product
  function automatic logic [2*W-1:0] model_product(input logic sgn,
                                                   input logic [W-1:0] a,
                                                   input logic [W-1:0] b);
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    if (sgn) begin
      sa = (2*W)'(signed'(a));
      sb = (2*W)'(signed'(b));
    end else begin
      sa = (2*W)'(a);
      sb = (2*W)'(b);
    end
    return sa * sb;
  endfunction

  // Quotient toward zero, remainder carries the divisor sign
  function automatic math_unit_pkg::div_word_t model_divide(input logic sgn,
                                                            input logic [W-1:0] a,
                                                            input logic [W-1:0] b);
    logic signed [2*W-1:0]    sa;
    logic signed [2*W-1:0]    sb;
    logic signed [2*W-1:0]    q;
    logic signed [2*W-1:0]    r;
    math_unit_pkg::div_word_t res;
    res = '0;
    if (b == '0)
      return res;
    if (sgn) begin
      sa = (2*W)'(signed'(a));
      sb = (2*W)'(signed'(b));
    end else begin
      sa = (2*W)'(a);
      sb = (2*W)'(b);
    end
    q = sa / sb;
    r = sa % sb;
    if ((r != '0) && (r[2*W-1] != sb[2*W-1]))
      r = r + sb;
    res.quot = q[W-1:0];
    res.rem  = r[W-1:0];
    return res;
  endfunction

  task automatic check_result();
    logic [2*W-1:0] want;
    int             due;
    phase_checks++;
    if (result_op == math_unit_pkg::OP_MUL) begin
      if (mul_exp.size() == 0) begin
        $display("unexpected result at %0t: a product came back with no multiply waiting",
                 $time);
        phase_errors++;
      end else begin
        want = mul_exp.pop_front();
        due  = mul_due.pop_front();
        if (result.mul != want) begin
          $display("mismatch at %0t: product expected %h, got %h", $time, want, result.mul);
          phase_errors++;
        end else if (cycle_no != due) begin
          $display("mismatch at %0t: product in cycle %0d, expected in cycle %0d",
                   $time, cycle_no, due);
          phase_errors++;
        end
      end
    end else if (!div_expected) begin
      $display("unexpected result at %0t: a divide result came back with no divide waiting",
               $time);
      phase_errors++;
    end else begin
      div_expected = 1'b0;
      if (result.div != div_exp) begin
        $display("mismatch at %0t: quot/rem expected %h/%h, got %h/%h", $time,
                 div_exp.quot, div_exp.rem, result.div.quot, result.div.rem);
        phase_errors++;
      end
    end
  endtask

  // Inputs and outputs are both read as the DUT sees them on this edge
  always @(posedge clk) begin
    cycle_no = cycle_no + 1;
    if (rst_n) begin
      if (result_valid)
        check_result();
      // Busy covers a divide from its start until its result is out
      if (div_busy != div_expected) begin
        $display("mismatch at %0t: div_busy is %b, expected %b",
                 $time, div_busy, div_expected);
        phase_errors++;
      end
      if (mul_start) begin
        mul_exp.push_back(model_product(is_signed, left, right));
        mul_due.push_back(cycle_no + 3);
      end
      if (div_start && !div_expected) begin
        div_exp      = model_divide(is_signed, left, right);
        div_expected = 1'b1;
      end
    end
  end

  function automatic int outstanding();
    return mul_exp.size() + (div_expected ? 1 : 0);
  endfunction

  task automatic report_phase(input string name);
    $display("phase %s: %0d checks, %0d errors", name, phase_checks, phase_errors);
    total_checks += phase_checks;
    total_errors += phase_errors;
    phase_checks = 0;
    phase_errors = 0;
  endtask

endmodule

// ==== bench/math_unit_tb.sv ====
/*
  Testbench for the integer math unit
  Clock and reset, seeded random stimulus in six phases,
  run-length watchdog and the final report
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module math_unit_tb;
  localparam int W           = `MATH_WIDTH;
  localparam int PHASES      = 6;
  localparam int OPS         = 24;
  localparam int CYCLE_LIMIT = PHASES * OPS * (W + 8) + 500;

  logic                        clk;
  logic                        rst_n;
  logic                        mul_start;
  logic                        div_start;
  logic                        is_signed;
  logic [W-1:0]                left;
  logic [W-1:0]                right;
  logic                        result_valid;
  math_unit_pkg::op_e          result_op;
  math_unit_pkg::result_word_u result;
  logic                        div_busy;
  int                          cycle_count;
  int                          errors;
  int                          burst;
  logic [W-1:0]                op_a;
  logic [W-1:0]                op_b;

  math_unit_top dut0 (
    .clk (clk), .rst_n (rst_n), .mul_start (mul_start), .div_start (div_start),
    .is_signed (is_signed), .left (left), .right (right), .result_valid (result_valid),
    .result_op (result_op), .result (result), .div_busy (div_busy)
  );

  math_unit_scoreboard sb0 (
    .clk (clk), .rst_n (rst_n), .mul_start (mul_start), .div_start (div_start),
    .is_signed (is_signed), .left (left), .right (right), .result_valid (result_valid),
    .result_op (result_op), .result (result), .div_busy (div_busy)
  );

  bind math_unit_top math_unit_chk chk0 (
    .clk (clk), .rst_n (rst_n), .mul_start (mul_start), .result_valid (result_valid),
    .result_op (result_op), .div_busy (div_busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random magnitude spread over the whole width
  function automatic logic [W-1:0] rand_word();
    logic [W-1:0] v;
    v = $urandom;
    return v >> ($urandom % W);
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end
  endtask

  task automatic issue_mul(input logic sgn, input logic [W-1:0] a, input logic [W-1:0] b);
    @(posedge clk);
    mul_start <= 1'b1;
    div_start <= 1'b0;
    is_signed <= sgn;
    left      <= a;
    right     <= b;
  endtask

  // Waits out a running divide, then strobes for one cycle
  task automatic issue_div(input logic sgn, input logic [W-1:0] a, input logic [W-1:0] b);
    @(posedge clk);
    mul_start <= 1'b0;
    while (div_busy)
      @(posedge clk);
    div_start <= 1'b1;
    is_signed <= sgn;
    left      <= a;
    right     <= b;
    @(posedge clk);
    div_start <= 1'b0;
  endtask

  task automatic drain_and_report(input string name);
    do
      @(negedge clk);
    while (sb0.outstanding() != 0 || div_busy);
    sb0.report_phase(name);
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(56729));
    rst_n     = 1'b0;
    mul_start = 1'b0;
    div_start = 1'b0;
    is_signed = 1'b0;
    left      = '0;
    right     = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    idle(2);

    for (int i = 0; i < OPS; i++) begin
      issue_mul(1'b0, (i == 0) ? '1 : rand_word(), (i == 0) ? '1 : rand_word());
      if ($urandom % 3 == 0)
        idle(1 + $urandom % 3);
    end
    idle(1);
    drain_and_report("unsigned multiply");

    // Most negative operands first, then random signs
    for (int i = 0; i < OPS; i++) begin
      op_a = (i < 2) ? {1'b1, {(W-1){1'b0}}} : ($urandom % 2 ? -rand_word() : rand_word());
      op_b = (i < 1) ? {1'b1, {(W-1){1'b0}}} : ($urandom % 2 ? -rand_word() : rand_word());
      issue_mul(1'b1, op_a, op_b);
      if ($urandom % 3 == 0)
        idle(1 + $urandom % 3);
    end
    idle(1);
    drain_and_report("signed multiply");

    for (int i = 0; i < OPS; i++) begin
      op_b = rand_word();
      issue_div(1'b0, rand_word(), (op_b == '0) ? 1 : op_b);
    end
    drain_and_report("unsigned divide");

    // Index bits pick the operand signs, the first case overflows
    for (int i = 0; i < OPS; i++) begin
      op_a = rand_word() >> 1;
      op_b = (rand_word() >> 1) | 1;
      op_a = i[0] ? -op_a : op_a;
      op_b = i[1] ? -op_b : op_b;
      if (i == 0)
        issue_div(1'b1, {1'b1, {(W-1){1'b0}}}, '1);
      else
        issue_div(1'b1, op_a, op_b);
    end
    drain_and_report("signed divide");

    for (int i = 0; i < OPS; i++)
      issue_div(i[0], rand_word(), '0);
    drain_and_report("divide by zero");

    // Multiply bursts placed over the divide's finishing cycles
    for (int i = 0; i < OPS; i++) begin
      op_b = rand_word();
      issue_div(i[0], rand_word(), (op_b == '0) ? 1 : op_b);
      idle(22 + $urandom % 10);
      burst = 6 + $urandom % 8;
      for (int k = 0; k < burst; k++)
        issue_mul(1'($urandom % 2), rand_word(), rand_word());
      idle(1);
    end
    drain_and_report("contention");

    errors = sb0.total_errors + dut0.chk0.fail_count;
    $display("summary: %0d checks, %0d errors, %0d assertion failures",
             sb0.total_checks, sb0.total_errors, dut0.chk0.fail_count);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/math_unit_pkg.sv
hw/mul_pipe.sv
hw/div_core.sv
hw/div_sign_unit.sv
hw/result_arbiter.sv
hw/math_unit_top.sv
bench/math_unit_chk.sv
bench/math_unit_scoreboard.sv
bench/math_unit_tb.sv

// ==== hw/div_core.sv ====
/*
  Unsigned restoring divider
  One quotient bit per cycle, MSB first, under an iteration counter
  A zero divisor returns zero quotient and remainder on the next edge
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module div_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [`MATH_WIDTH-1:0] dividend,
  input  logic [`MATH_WIDTH-1:0] divisor,
  output logic                   done,
  output logic [`MATH_WIDTH-1:0] quotient,
  output logic [`MATH_WIDTH-1:0] remainder
);
  localparam int W = `MATH_WIDTH;

  logic [2*W-2:0]             div_sh;
  logic [W-1:0]               rem_acc;
  logic [W-1:0]               quot_acc;
  logic [W-1:0]               quot_msk;
  logic [`MATH_CNT_WIDTH-1:0] iter;
  logic                       running;
  logic                       accept;
  logic                       zero_div;
  logic                       last;
  logic                       fits;
  logic [W-1:0]               rem_next;
  logic [W-1:0]               quot_next;

  assign accept   = start && !running;
  assign zero_div = accept && (divisor == '0);
  assign last     = running && (iter == (`MATH_CNT_WIDTH)'(W - 1));

  // Trial subtraction of the shifted divisor
  assign fits      = div_sh <= {{(W-1){1'b0}}, rem_acc};
  assign rem_next  = fits ? rem_acc - div_sh[W-1:0] : rem_acc;
  assign quot_next = fits ? quot_acc | quot_msk : quot_acc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
      done    <= 1'b0;
      iter    <= '0;
    end else begin
      done <= zero_div | last;
      if (last)
        running <= 1'b0;
      else if (accept && !zero_div)
        running <= 1'b1;
      if (accept)
        iter <= '0;
      else if (running)
        iter <= iter + 1'b1;
    end
  end

  // Divisor starts aligned under the dividend MSB and walks right
  always_ff @(posedge clk) begin
    if (accept) begin
      div_sh   <= {divisor, {(W-1){1'b0}}};
      rem_acc  <= dividend;
      quot_acc <= '0;
      quot_msk <= {1'b1, {(W-1){1'b0}}};
    end else if (running) begin
      div_sh   <= div_sh >> 1;
      rem_acc  <= rem_next;
      quot_acc <= quot_next;
      quot_msk <= quot_msk >> 1;
    end
  end

  // Outputs hold until the next operation finishes
  always_ff @(posedge clk) begin
    if (zero_div) begin
      quotient  <= '0;
      remainder <= '0;
    end else if (last) begin
      quotient  <= quot_next;
      remainder <= rem_next;
    end
  end

endmodule

// ==== hw/div_sign_unit.sv ====
/*
  Signed wrapper around the unsigned divider core
  Takes magnitudes in, restores signs on completion,
  holds the result until the arbiter grants it, owns the busy flag
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module div_sign_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     is_signed,
  input  logic [`MATH_WIDTH-1:0]   left,
  input  logic [`MATH_WIDTH-1:0]   right,
  input  logic                     grant,
  output logic                     busy,
  output logic                     pending,
  output math_unit_pkg::div_word_t result
);
  localparam int W = `MATH_WIDTH;

  logic         accept;
  logic         left_neg;
  logic         right_neg;
  logic         left_sign;
  logic         right_sign;
  logic         diff_signs;
  logic [W-1:0] left_abs;
  logic [W-1:0] right_abs;
  logic [W-1:0] right_save;
  logic         core_done;
  logic [W-1:0] core_quot;
  logic [W-1:0] core_rem;
  logic [W-1:0] rem_mid;

  assign accept    = start && !busy;
  assign left_neg  = is_signed & left[W-1];
  assign right_neg = is_signed & right[W-1];
  assign left_abs  = left_neg ? -left : left;
  assign right_abs = right_neg ? -right : right;

  // Floored remainder, follows the divisor sign
  assign diff_signs = left_sign ^ right_sign;
  assign rem_mid    = (diff_signs && |core_rem) ? right_save - core_rem : core_rem;

  div_core core0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (accept),
    .dividend  (left_abs),
    .divisor   (right_abs),
    .done      (core_done),
    .quotient  (core_quot),
    .remainder (core_rem)
  );

  always_ff @(posedge clk) begin
    if (accept) begin
      left_sign  <= left_neg;
      right_sign <= right_neg;
      right_save <= right_abs;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (accept)
        busy <= 1'b1;
      else if (grant)
        busy <= 1'b0;
      if (core_done)
        pending <= 1'b1;
      else if (grant)
        pending <= 1'b0;
    end
  end

  // Quotient truncates toward zero
  always_ff @(posedge clk) begin
    if (core_done) begin
      result.quot <= diff_signs ? -core_quot : core_quot;
      result.rem  <= right_sign ? -rem_mid : rem_mid;
    end
  end

endmodule

// ==== hw/math_unit_macros.svh ====
/*
  Width macros for the integer math unit
  Operand width and the divider iteration counter size
*/
`ifndef MATH_UNIT_MACROS_SVH
`define MATH_UNIT_MACROS_SVH

// Operand width in bits, the results are two words wide
`define MATH_WIDTH 32

// Holds every step index of the divider plus one spare count
`define MATH_CNT_WIDTH ($clog2(`MATH_WIDTH) + 1)

`endif

// ==== hw/math_unit_pkg.sv ====
/*
  Shared types for the integer math unit
  Operation tag, multiply and divide result words,
  and the union carried on the shared result bus
*/
package math_unit_pkg;

  `include "math_unit_macros.svh"

  typedef enum logic {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } op_e;

  typedef struct packed {
    logic [`MATH_WIDTH-1:0] hi;
    logic [`MATH_WIDTH-1:0] lo;
  } mul_word_t;

  typedef struct packed {
    logic [`MATH_WIDTH-1:0] quot;
    logic [`MATH_WIDTH-1:0] rem;
  } div_word_t;

  // The tag on the bus says which view is valid
  typedef union packed {
    mul_word_t mul;
    div_word_t div;
  } result_word_u;

endpackage

// ==== hw/math_unit_top.sv ====
/*
  Integer math unit top level
  Pipelined multiplier and iterative divider sharing one
  registered result bus through a priority arbiter
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module math_unit_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        mul_start,
  input  logic                        div_start,
  input  logic                        is_signed,
  input  logic [`MATH_WIDTH-1:0]      left,
  input  logic [`MATH_WIDTH-1:0]      right,
  output logic                        result_valid,
  output math_unit_pkg::op_e          result_op,
  output math_unit_pkg::result_word_u result,
  output logic                        div_busy
);

  logic                     mul_valid;
  math_unit_pkg::mul_word_t mul_result;
  logic                     div_pending;
  math_unit_pkg::div_word_t div_result;
  logic                     div_grant;

  mul_pipe mul0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (mul_start),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .valid     (mul_valid),
    .result    (mul_result)
  );

  div_sign_unit div0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (div_start),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .grant     (div_grant),
    .busy      (div_busy),
    .pending   (div_pending),
    .result    (div_result)
  );

  result_arbiter arb0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .mul_valid    (mul_valid),
    .mul_result   (mul_result),
    .div_pending  (div_pending),
    .div_result   (div_result),
    .div_grant    (div_grant),
    .result_valid (result_valid),
    .result_op    (result_op),
    .result       (result)
  );

endmodule

// ==== hw/mul_pipe.sv ====
/*
  Two-stage multiply pipeline
  Stage 1 registers the extended operands, stage 2 the full product
  Signed or unsigned per operation, one new operation per cycle
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module mul_pipe (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      is_signed,
  input  logic [`MATH_WIDTH-1:0]    left,
  input  logic [`MATH_WIDTH-1:0]    right,
  output logic                      valid,
  output math_unit_pkg::mul_word_t  result
);
  localparam int W = `MATH_WIDTH;

  logic           s1_valid;
  logic [2*W-1:0] s1_left;
  logic [2*W-1:0] s1_right;
  logic [2*W-1:0] product;

  // Low half of a double-width product is the same for both signednesses
  assign product = s1_left * s1_right;

  // Valid bits shadow the data through both stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      valid    <= 1'b0;
    end else begin
      s1_valid <= start;
      valid    <= s1_valid;
    end
  end

  // Stage 1, operands widened to the product width
  always_ff @(posedge clk) begin
    if (start) begin
      s1_left  <= {{W{is_signed & left[W-1]}}, left};
      s1_right <= {{W{is_signed & right[W-1]}}, right};
    end
  end

  // Stage 2
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result.hi <= product[2*W-1:W];
      result.lo <= product[W-1:0];
    end
  end

endmodule

// ==== hw/result_arbiter.sv ====
/*
  Fixed-priority arbiter for the shared result bus
  Multiplier always wins, divider goes when the multiplier is idle
  Registers the winning word, its tag and the valid pulse
*/
`timescale 1ns/1ps
`include "math_unit_macros.svh"

module result_arbiter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        mul_valid,
  input  math_unit_pkg::mul_word_t    mul_result,
  input  logic                        div_pending,
  input  math_unit_pkg::div_word_t    div_result,
  output logic                        div_grant,
  output logic                        result_valid,
  output math_unit_pkg::op_e          result_op,
  output math_unit_pkg::result_word_u result
);

  // Multiplier has no back-pressure, so it never waits
  assign div_grant = div_pending && !mul_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result_op    <= math_unit_pkg::OP_MUL;
    end else begin
      result_valid <= mul_valid | div_grant;
      if (mul_valid)
        result_op <= math_unit_pkg::OP_MUL;
      else if (div_grant)
        result_op <= math_unit_pkg::OP_DIV;
    end
  end

  // Payload written through the view that matches the tag
  always_ff @(posedge clk) begin
    if (mul_valid)
      result.mul <= mul_result;
    else if (div_grant)
      result.div <= div_result;
  end

endmodule
